/* source/vseq_pkg.sv */
// Vector sequencer shared definitions
// Sizes, ID and register types, the operation set and its mapping onto units
`default_nettype none

package vseq_pkg;

  // Instructions in flight and architectural vector registers
  localparam int unsigned NR_VINSN  = 8;
  localparam int unsigned NR_VREGS  = 32;
  localparam int unsigned VMASK_REG = 0;
  localparam int unsigned NR_UNITS  = 4;

  typedef logic [$clog2(NR_VINSN)-1:0] vid_t;
  typedef logic [$clog2(NR_VREGS)-1:0] vreg_t;
  typedef logic [NR_VINSN-1:0]         insn_mask_t;
  typedef logic [NR_UNITS-1:0]         unit_mask_t;
  // Wide enough for queue depths up to 7
  typedef logic [2:0]                  cnt_t;

  typedef enum logic [1:0] {UNIT_ALU, UNIT_MUL, UNIT_LOAD, UNIT_STORE} unit_e;

  typedef enum logic [2:0] {OP_ADD, OP_SUB, OP_MUL, OP_LOAD, OP_STORE} op_e;

  // Unit that executes a given operation
  function automatic unit_e unit_of(op_e op);
    unit_e unit;
    case (op)
      OP_MUL:   unit = UNIT_MUL;
      OP_LOAD:  unit = UNIT_LOAD;
      OP_STORE: unit = UNIT_STORE;
      default:  unit = UNIT_ALU;
    endcase
    return unit;
  endfunction

  // Every unit that takes part in an instruction
  // Masked operations also pull v0 through the load unit
  function automatic unit_mask_t unit_targets(unit_e unit, logic vm);
    unit_mask_t mask;
    mask            = '0;
    mask[unit]      = 1'b1;
    mask[UNIT_LOAD] = mask[UNIT_LOAD] | ~vm;
    return mask;
  endfunction

endpackage

`default_nettype wire

/* source/vseq_issue_if.sv */
// Accepted-instruction event bus
// Driven by the issue control, observed by the tracker, scoreboard and counters
`timescale 1ns/100ps
`default_nettype none

interface vseq_issue_if;
  import vseq_pkg::*;

  // One-cycle strobe, the fields below are valid whenever a request is pending
  logic  issue;
  vid_t  id;
  unit_e unit;
  vreg_t vd;
  vreg_t vs1;
  vreg_t vs2;
  logic  use_vd;
  logic  use_vs1;
  logic  use_vs2;
  // Low for masked operations
  logic  vm;

  modport ctrl (output issue, id, unit, vd, vs1, vs2, use_vd, use_vs1, use_vs2, vm);
  modport sink (input issue, id, unit, vd, vs1, vs2, use_vd, use_vs1, use_vs2, vm);

endinterface

`default_nettype wire

/* source/vinsn_tracker.sv */
// Running instruction tracker
// Keeps the per-unit running matrix and hands out the lowest free instruction ID
`timescale 1ns/100ps
`default_nettype none

module vinsn_tracker (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  vseq_issue_if.sink                                     issue_i,
  input  vseq_pkg::insn_mask_t [vseq_pkg::NR_UNITS-1:0] vinsn_done_i,
  output vseq_pkg::vid_t                                 free_id_o,
  output logic                                           full_o,
  output vseq_pkg::insn_mask_t                           vinsn_running_o,
  output logic                                           idle_o
);
  import vseq_pkg::*;

  insn_mask_t [NR_UNITS-1:0] running_q, running_d;
  insn_mask_t                running_all;
  unit_mask_t                targets;

  assign targets = unit_targets(issue_i.unit, issue_i.vm);

  // Done pulses retire bits, a new issue marks the ID in every unit it touches
  always_comb begin
    for (int u = 0; u < NR_UNITS; u++) begin
      running_d[u] = running_q[u] & ~vinsn_done_i[u];
      if (issue_i.issue && targets[u]) running_d[u][issue_i.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end

  // An ID is busy while any unit still holds it
  always_comb begin
    running_all = '0;
    for (int u = 0; u < NR_UNITS; u++) running_all |= running_q[u];
  end

  // Scan from the top so the lowest clear bit wins
  always_comb begin
    free_id_o = '0;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (!running_all[i]) free_id_o = vid_t'(i);
    end
  end

  assign full_o          = &running_all;
  assign idle_o          = ~|running_all;
  assign vinsn_running_o = running_all;

endmodule

`default_nettype wire

/* source/vreg_scoreboard.sv */
// Vector register scoreboard
// Tracks the last reader and writer of each register, derives RAW/WAR/WAW
// hazard vectors and maintains the global hazard table
`timescale 1ns/100ps
`default_nettype none

module vreg_scoreboard (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  vseq_issue_if.sink                                     issue_i,
  input  vseq_pkg::insn_mask_t                           vinsn_running_i,
  output vseq_pkg::insn_mask_t                           hazard_vs1_o,
  output vseq_pkg::insn_mask_t                           hazard_vs2_o,
  output vseq_pkg::insn_mask_t                           hazard_vm_o,
  output vseq_pkg::insn_mask_t                           hazard_vd_o,
  output vseq_pkg::insn_mask_t [vseq_pkg::NR_VINSN-1:0] global_hazard_table_o
);
  import vseq_pkg::*;

  // Last writer and last reader of every register
  vid_t [NR_VREGS-1:0]       wr_vid_q, wr_vid_d, rd_vid_q, rd_vid_d;
  logic [NR_VREGS-1:0]       wr_vld_q, wr_vld_d, rd_vld_q, rd_vld_d;
  // Entries whose owner is still running
  logic [NR_VREGS-1:0]       wr_live, rd_live;
  insn_mask_t [NR_VINSN-1:0] table_q, table_d;
  insn_mask_t                hazard_all;

  always_comb begin
    for (int r = 0; r < NR_VREGS; r++) begin
      wr_live[r] = wr_vld_q[r] & vinsn_running_i[wr_vid_q[r]];
      rd_live[r] = rd_vld_q[r] & vinsn_running_i[rd_vid_q[r]];
    end
  end

  ////////////////////
  // Hazards
  ////////////////////

  always_comb begin
    hazard_vs1_o = '0;
    hazard_vs2_o = '0;
    hazard_vm_o  = '0;
    hazard_vd_o  = '0;
    // Read after write on the sources and on the mask register
    if (issue_i.use_vs1 && wr_live[issue_i.vs1]) hazard_vs1_o[wr_vid_q[issue_i.vs1]] = 1'b1;
    if (issue_i.use_vs2 && wr_live[issue_i.vs2]) hazard_vs2_o[wr_vid_q[issue_i.vs2]] = 1'b1;
    if (!issue_i.vm && wr_live[VMASK_REG]) hazard_vm_o[wr_vid_q[VMASK_REG]] = 1'b1;
    if (issue_i.use_vd) begin
      // Write after read is reported on every source vector
      if (rd_live[issue_i.vd]) begin
        hazard_vs1_o[rd_vid_q[issue_i.vd]] = 1'b1;
        hazard_vs2_o[rd_vid_q[issue_i.vd]] = 1'b1;
        hazard_vm_o[rd_vid_q[issue_i.vd]]  = 1'b1;
      end
      // Write after write
      if (wr_live[issue_i.vd]) hazard_vd_o[wr_vid_q[issue_i.vd]] = 1'b1;
    end
  end

  assign hazard_all = hazard_vs1_o | hazard_vs2_o | hazard_vm_o | hazard_vd_o;

  ////////////////////
  // List update
  ////////////////////

  always_comb begin
    wr_vid_d = wr_vid_q;
    rd_vid_d = rd_vid_q;
    wr_vld_d = wr_live;
    rd_vld_d = rd_live;
    table_d  = table_q;
    for (int i = 0; i < NR_VINSN; i++) table_d[i] &= vinsn_running_i;
    if (issue_i.issue) begin
      if (issue_i.use_vd) begin
        wr_vid_d[issue_i.vd] = issue_i.id;
        wr_vld_d[issue_i.vd] = 1'b1;
      end
      if (issue_i.use_vs1) begin
        rd_vid_d[issue_i.vs1] = issue_i.id;
        rd_vld_d[issue_i.vs1] = 1'b1;
      end
      if (issue_i.use_vs2) begin
        rd_vid_d[issue_i.vs2] = issue_i.id;
        rd_vld_d[issue_i.vs2] = 1'b1;
      end
      if (!issue_i.vm) begin
        rd_vid_d[VMASK_REG] = issue_i.id;
        rd_vld_d[VMASK_REG] = 1'b1;
      end
      // Row of the new instruction lists everything it waits for
      table_d[issue_i.id] = hazard_all;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_vld_q <= '0;
      rd_vld_q <= '0;
      table_q  <= '0;
    end else begin
      wr_vld_q <= wr_vld_d;
      rd_vld_q <= rd_vld_d;
      table_q  <= table_d;
    end
  end

  always_ff @(posedge clk_i) begin
    wr_vid_q <= wr_vid_d;
    rd_vid_q <= rd_vid_d;
  end

  // Finished producers drop out of every row in the cycle they stop running
  always_comb begin
    for (int i = 0; i < NR_VINSN; i++) global_hazard_table_o[i] = table_q[i] & vinsn_running_i;
  end

endmodule

`default_nettype wire

/* source/unit_queue_counters.sv */
// Per-unit instruction queue occupancy
// Counts issued but unfinished instructions and flags units with room left
`timescale 1ns/100ps
`default_nettype none

module unit_queue_counters #(
  parameter int unsigned QUEUE_DEPTH = 2
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  vseq_issue_if.sink                                     issue_i,
  input  vseq_pkg::insn_mask_t [vseq_pkg::NR_UNITS-1:0] vinsn_done_i,
  output vseq_pkg::unit_mask_t                           unit_ready_o
);
  import vseq_pkg::*;

  cnt_t [NR_UNITS-1:0] cnt_q;
  unit_mask_t          targets;
  unit_mask_t          cnt_up;
  unit_mask_t          cnt_down;

  assign targets = unit_targets(issue_i.unit, issue_i.vm);

  for (genvar u = 0; u < NR_UNITS; u++) begin : gen_cnt
    assign cnt_up[u]   = issue_i.issue & targets[u];
    // Any finishing instruction frees one slot of this unit
    assign cnt_down[u] = |vinsn_done_i[u];

    // Simultaneous issue and retire leave the count as it is
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[u] <= '0;
      end else if (cnt_up[u] && !cnt_down[u]) begin
        cnt_q[u] <= cnt_q[u] + cnt_t'(1);
      end else if (cnt_down[u] && !cnt_up[u]) begin
        cnt_q[u] <= cnt_q[u] - cnt_t'(1);
      end
    end

    assign unit_ready_o[u] = cnt_q[u] < cnt_t'(QUEUE_DEPTH);
  end

endmodule

`default_nettype wire

/* source/issue_ctrl.sv */
// Issue control of the vector sequencer
// Decides acceptance, holds the request towards the units and waits for
// address generation on loads and stores
`timescale 1ns/100ps
`default_nettype none

module issue_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_valid_i,
  input  vseq_pkg::op_e        req_op_i,
  input  vseq_pkg::vreg_t      req_vd_i,
  input  vseq_pkg::vreg_t      req_vs1_i,
  input  vseq_pkg::vreg_t      req_vs2_i,
  input  logic                 req_use_vd_i,
  input  logic                 req_use_vs1_i,
  input  logic                 req_use_vs2_i,
  input  logic                 req_vm_i,
  output logic                 req_ready_o,
  output logic                 pe_req_valid_o,
  input  logic                 pe_req_ready_i,
  output vseq_pkg::vid_t       pe_req_id_o,
  output vseq_pkg::op_e        pe_req_op_o,
  output vseq_pkg::unit_e      pe_req_unit_o,
  output vseq_pkg::insn_mask_t pe_hazard_o,
  input  logic                 addrgen_ack_i,
  output logic                 resp_valid_o,
  input  vseq_pkg::vid_t       free_id_i,
  input  logic                 full_i,
  input  vseq_pkg::insn_mask_t hazard_vs1_i,
  input  vseq_pkg::insn_mask_t hazard_vs2_i,
  input  vseq_pkg::insn_mask_t hazard_vm_i,
  input  vseq_pkg::insn_mask_t hazard_vd_i,
  input  vseq_pkg::unit_mask_t unit_ready_i,
  vseq_issue_if.ctrl           issue_o
);
  import vseq_pkg::*;

  // WAIT covers the window between a memory issue and its address acknowledge
  typedef enum logic {IDLE, WAIT} seq_state_e;

  seq_state_e state_q, state_d;
  unit_e      req_unit;
  unit_mask_t req_targets;
  insn_mask_t hazard_all;
  logic       is_mem, held, units_ok, load_stall, accept;

  assign req_unit    = unit_of(req_op_i);
  assign req_targets = unit_targets(req_unit, req_vm_i);
  assign hazard_all  = hazard_vs1_i | hazard_vs2_i | hazard_vm_i | hazard_vd_i;
  assign is_mem      = (req_unit == UNIT_LOAD) || (req_unit == UNIT_STORE);

  // Blocking conditions
  // A previous request still waits for the units
  assign held       = pe_req_valid_o & ~pe_req_ready_i;
  assign units_ok   = &(unit_ready_i | ~req_targets);
  // Loads without vector operands cannot chain, so they wait out any hazard
  assign load_stall = (req_op_i == OP_LOAD) & req_vm_i & ~req_use_vs1_i & ~req_use_vs2_i &
                      (|hazard_all);

  assign req_ready_o  = (state_q == IDLE) & ~held & ~full_i & units_ok & ~load_stall;
  assign accept       = req_valid_i & req_ready_o;
  assign resp_valid_o = (state_q == WAIT) & addrgen_ack_i;

  // The pending request is always visible so hazards can be looked up early
  assign issue_o.issue   = accept;
  assign issue_o.id      = free_id_i;
  assign issue_o.unit    = req_unit;
  assign issue_o.vd      = req_vd_i;
  assign issue_o.vs1     = req_vs1_i;
  assign issue_o.vs2     = req_vs2_i;
  assign issue_o.use_vd  = req_use_vd_i;
  assign issue_o.use_vs1 = req_use_vs1_i;
  assign issue_o.use_vs2 = req_use_vs2_i;
  assign issue_o.vm      = req_vm_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept && is_mem) state_d = WAIT;
      WAIT:    if (addrgen_ack_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      pe_req_valid_o <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) pe_req_valid_o <= 1'b1;
      else if (pe_req_ready_i) pe_req_valid_o <= 1'b0;
    end
  end

  // Request payload only changes on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pe_req_id_o   <= free_id_i;
      pe_req_op_o   <= req_op_i;
      pe_req_unit_o <= req_unit;
      pe_hazard_o   <= hazard_all;
    end
  end

endmodule

`default_nettype wire

/* source/vseq_top.sv */
// Vector instruction sequencer top level
// Connects issue control, ID tracker, register scoreboard and queue counters
`timescale 1ns/100ps
`default_nettype none

module vseq_top #(
  parameter int unsigned QUEUE_DEPTH = 2
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           req_valid_i,
  input  vseq_pkg::op_e                                  req_op_i,
  input  vseq_pkg::vreg_t                                req_vd_i,
  input  vseq_pkg::vreg_t                                req_vs1_i,
  input  vseq_pkg::vreg_t                                req_vs2_i,
  input  logic                                           req_use_vd_i,
  input  logic                                           req_use_vs1_i,
  input  logic                                           req_use_vs2_i,
  input  logic                                           req_vm_i,
  output logic                                           req_ready_o,
  output logic                                           pe_req_valid_o,
  input  logic                                           pe_req_ready_i,
  output vseq_pkg::vid_t                                 pe_req_id_o,
  output vseq_pkg::op_e                                  pe_req_op_o,
  output vseq_pkg::unit_e                                pe_req_unit_o,
  output vseq_pkg::insn_mask_t                           pe_hazard_o,
  input  vseq_pkg::insn_mask_t [vseq_pkg::NR_UNITS-1:0] vinsn_done_i,
  input  logic                                           addrgen_ack_i,
  output logic                                           resp_valid_o,
  output logic                                           idle_o,
  output vseq_pkg::insn_mask_t                           vinsn_running_o,
  output vseq_pkg::insn_mask_t [vseq_pkg::NR_VINSN-1:0] global_hazard_table_o
);
  import vseq_pkg::*;

  vid_t       free_id;
  logic       full;
  insn_mask_t hazard_vs1, hazard_vs2, hazard_vm, hazard_vd;
  unit_mask_t unit_ready;

  // Accepted-instruction event shared by the datapath blocks
  vseq_issue_if issue_bus ();

  issue_ctrl u_issue_ctrl (
    .clk_i, .rst_ni, .req_valid_i, .req_op_i, .req_vd_i, .req_vs1_i, .req_vs2_i,
    .req_use_vd_i, .req_use_vs1_i, .req_use_vs2_i, .req_vm_i, .req_ready_o,
    .pe_req_valid_o, .pe_req_ready_i, .pe_req_id_o, .pe_req_op_o, .pe_req_unit_o,
    .pe_hazard_o, .addrgen_ack_i, .resp_valid_o,
    .free_id_i    (free_id),
    .full_i       (full),
    .hazard_vs1_i (hazard_vs1),
    .hazard_vs2_i (hazard_vs2),
    .hazard_vm_i  (hazard_vm),
    .hazard_vd_i  (hazard_vd),
    .unit_ready_i (unit_ready),
    .issue_o      (issue_bus)
  );

  vinsn_tracker u_vinsn_tracker (
    .clk_i, .rst_ni, .vinsn_done_i, .vinsn_running_o, .idle_o,
    .issue_i   (issue_bus),
    .free_id_o (free_id),
    .full_o    (full)
  );

  vreg_scoreboard u_vreg_scoreboard (
    .clk_i, .rst_ni, .global_hazard_table_o,
    .issue_i         (issue_bus),
    .vinsn_running_i (vinsn_running_o),
    .hazard_vs1_o    (hazard_vs1),
    .hazard_vs2_o    (hazard_vs2),
    .hazard_vm_o     (hazard_vm),
    .hazard_vd_o     (hazard_vd)
  );

  unit_queue_counters #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_unit_queue_counters (
    .clk_i, .rst_ni, .vinsn_done_i,
    .issue_i      (issue_bus),
    .unit_ready_o (unit_ready)
  );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// Clock and reset source for the sequencer testbench
// Free-running clock, reset held low for a fixed number of cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 4,
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset is released shortly after a rising edge, like every other input
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* verification/tb_vseq.sv */
// Testbench of the vector sequencer
// Directed and random instruction streams checked against a behavioral model
// of the ID pool, the register lists and the hazard table
`timescale 1ns/100ps
`default_nettype none

module tb_vseq;
  import vseq_pkg::*;

  localparam int unsigned QUEUE_DEPTH  = 2;
  localparam int unsigned CLK_PERIOD   = 4;
  localparam int unsigned DRIVE_DELAY  = 1;
  localparam int unsigned NUM_RANDOM   = 200;
  localparam int unsigned ACCEPT_LIMIT = 100;
  // Rough upper bound of the cycles the whole stimulus needs
  localparam int unsigned STIM_CYCLES  = NUM_RANDOM * 12 + 400;
  localparam logic [31:0] SEED         = 32'h452d_81ff;

  typedef struct packed {
    vid_t       id;
    op_e        op;
    unit_e      unit;
    insn_mask_t hazard;
  } exp_req_t;

  logic clk, rst_n;
  logic req_valid_i, req_ready_o, pe_req_valid_o, pe_req_ready_i;
  op_e req_op_i, pe_req_op_o;
  vreg_t req_vd_i, req_vs1_i, req_vs2_i;
  logic req_use_vd_i, req_use_vs1_i, req_use_vs2_i, req_vm_i;
  vid_t pe_req_id_o;
  unit_e pe_req_unit_o;
  insn_mask_t pe_hazard_o, vinsn_running_o;
  insn_mask_t [NR_UNITS-1:0] vinsn_done_i;
  insn_mask_t [NR_VINSN-1:0] global_hazard_table_o;
  logic addrgen_ack_i, resp_valid_o, idle_o;

  // Reference model state
  insn_mask_t mrun [NR_UNITS];
  insn_mask_t mtable [NR_VINSN];
  vid_t wr_id [NR_VREGS];
  vid_t rd_id [NR_VREGS];
  logic wr_v [NR_VREGS];
  logic rd_v [NR_VREGS];
  logic mwait;
  vid_t last_id;
  exp_req_t exp_q [$];

  logic [31:0] rng_state, bp_state;
  logic bp_enable;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(5)) u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  vseq_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) DUT (
    .clk_i (clk), .rst_ni (rst_n), .req_valid_i, .req_op_i, .req_vd_i, .req_vs1_i,
    .req_vs2_i, .req_use_vd_i, .req_use_vs1_i, .req_use_vs2_i, .req_vm_i, .req_ready_o,
    .pe_req_valid_o, .pe_req_ready_i, .pe_req_id_o, .pe_req_op_o, .pe_req_unit_o,
    .pe_hazard_o, .vinsn_done_i, .addrgen_ack_i, .resp_valid_o, .idle_o,
    .vinsn_running_o, .global_hazard_table_o
  );

  ////////////////////
  // Failure reporting
  ////////////////////

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_vid(string name, vid_t got, vid_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0t: %s got %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_mask(string name, insn_mask_t got, insn_mask_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0t: %s got %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0t: %s got %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_op(string name, op_e got, op_e exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0t: %s got %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_unit(string name, unit_e got, unit_e exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0t: %s got %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Masked instructions hold the load unit for v0 as well as their own unit
  function automatic unit_mask_t unit_set(op_e op, logic vm);
    unit_mask_t m;
    m = '0;
    case (op)
      OP_MUL:   m[UNIT_MUL] = 1'b1;
      OP_LOAD:  m[UNIT_LOAD] = 1'b1;
      OP_STORE: m[UNIT_STORE] = 1'b1;
      default:  m[UNIT_ALU] = 1'b1;
    endcase
    if (!vm) m[UNIT_LOAD] = 1'b1;
    return m;
  endfunction

  function automatic unit_e main_unit(op_e op);
    if (op == OP_MUL) return UNIT_MUL;
    if (op == OP_LOAD) return UNIT_LOAD;
    if (op == OP_STORE) return UNIT_STORE;
    return UNIT_ALU;
  endfunction

  function automatic insn_mask_t running_set();
    insn_mask_t run;
    run = '0;
    for (int u = 0; u < NR_UNITS; u++) begin
      run = run | mrun[u];
    end
    return run;
  endfunction

  function automatic vid_t lowest_free(insn_mask_t run);
    for (int i = 0; i < NR_VINSN; i++) begin
      if (!run[i]) return vid_t'(i);
    end
    return '0;
  endfunction

  // RAW on the sources and v0, WAR and WAW on the destination
  function automatic insn_mask_t expected_hazard(vreg_t vd, vreg_t vs1, vreg_t vs2,
                                                 logic use_vd, logic use_vs1, logic use_vs2,
                                                 logic vm);
    insn_mask_t haz;
    haz = '0;
    if (use_vs1 && wr_v[vs1]) haz[wr_id[vs1]] = 1'b1;
    if (use_vs2 && wr_v[vs2]) haz[wr_id[vs2]] = 1'b1;
    if (!vm && wr_v[VMASK_REG]) haz[wr_id[VMASK_REG]] = 1'b1;
    if (use_vd && rd_v[vd]) haz[rd_id[vd]] = 1'b1;
    if (use_vd && wr_v[vd]) haz[wr_id[vd]] = 1'b1;
    return haz;
  endfunction

  task automatic model_accept();
    exp_req_t   e;
    unit_mask_t targets;
    e.id     = lowest_free(running_set());
    e.op     = req_op_i;
    e.unit   = main_unit(req_op_i);
    e.hazard = expected_hazard(req_vd_i, req_vs1_i, req_vs2_i, req_use_vd_i,
                               req_use_vs1_i, req_use_vs2_i, req_vm_i);
    exp_q.push_back(e);
    targets = unit_set(req_op_i, req_vm_i);
    for (int u = 0; u < NR_UNITS; u++) begin
      if (targets[u]) mrun[u][e.id] = 1'b1;
    end
    mtable[e.id] = e.hazard;
    if (req_use_vd_i) begin
      wr_id[req_vd_i] = e.id;
      wr_v[req_vd_i]  = 1'b1;
    end
    if (req_use_vs1_i) begin
      rd_id[req_vs1_i] = e.id;
      rd_v[req_vs1_i]  = 1'b1;
    end
    if (req_use_vs2_i) begin
      rd_id[req_vs2_i] = e.id;
      rd_v[req_vs2_i]  = 1'b1;
    end
    if (!req_vm_i) begin
      rd_id[VMASK_REG] = e.id;
      rd_v[VMASK_REG]  = 1'b1;
    end
    mwait   = (req_op_i == OP_LOAD) || (req_op_i == OP_STORE);
    last_id = e.id;
  endtask

  // An ID that no unit holds any more loses its list entries and table column
  task automatic model_retire(insn_mask_t [NR_UNITS-1:0] done);
    insn_mask_t run;
    for (int u = 0; u < NR_UNITS; u++) begin
      mrun[u] = mrun[u] & ~done[u];
    end
    run = running_set();
    for (int r = 0; r < NR_VREGS; r++) begin
      if (wr_v[r] && !run[wr_id[r]]) wr_v[r] = 1'b0;
      if (rd_v[r] && !run[rd_id[r]]) rd_v[r] = 1'b0;
    end
    for (int i = 0; i < NR_VINSN; i++) begin
      mtable[i] = mtable[i] & run;
    end
  endtask

  ////////////////////
  // Compare process
  ////////////////////

  // Sampled mid-cycle, where inputs and outputs have settled
  initial begin
    exp_req_t head;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        check_mask("vinsn_running_o", vinsn_running_o, running_set());
        check_bit("idle_o", idle_o, running_set() == '0);
        for (int i = 0; i < NR_VINSN; i++) begin
          check_mask($sformatf("global_hazard_table_o[%0d]", i), global_hazard_table_o[i],
                     mtable[i]);
        end
        check_bit("pe_req_valid_o", pe_req_valid_o, exp_q.size() != 0);
        check_bit("resp_valid_o", resp_valid_o, mwait && addrgen_ack_i);
        if (mwait) check_bit("req_ready_o", req_ready_o, 1'b0);
        if (pe_req_valid_o && pe_req_ready_i && exp_q.size() != 0) begin
          head = exp_q.pop_front();
          check_vid("pe_req_id_o", pe_req_id_o, head.id);
          check_op("pe_req_op_o", pe_req_op_o, head.op);
          check_unit("pe_req_unit_o", pe_req_unit_o, head.unit);
          check_mask("pe_hazard_o", pe_hazard_o, head.hazard);
        end
        if (mwait && addrgen_ack_i) mwait = 1'b0;
        if (req_valid_i && req_ready_o) model_accept();
        model_retire(vinsn_done_i);
      end
    end
  end

  // Unit back-pressure is random only while the random phase runs
  initial begin
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      bp_state       = xorshift32(bp_state);
      pe_req_ready_i = bp_enable ? bp_state[7] : 1'b1;
    end
  end

  initial begin
    #(CLK_PERIOD * STIM_CYCLES * 4);
    abort_run("Watchdog expired before the stimulus finished");
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic drive_req(op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2,
                           logic use_vd, logic use_vs1, logic use_vs2, logic vm);
    req_op_i      = op;
    req_vd_i      = vd;
    req_vs1_i     = vs1;
    req_vs2_i     = vs2;
    req_use_vd_i  = use_vd;
    req_use_vs1_i = use_vs1;
    req_use_vs2_i = use_vs2;
    req_vm_i      = vm;
    req_valid_i   = 1'b1;
  endtask

  task automatic wait_accept();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!req_ready_o && waited < ACCEPT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready_o) begin
      abort_run("Request was not accepted within the cycle limit");
    end else begin
      next_cycle();
      req_valid_i = 1'b0;
    end
  endtask

  task automatic issue_insn(op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2,
                            logic use_vd, logic use_vs1, logic use_vs2, logic vm);
    drive_req(op, vd, vs1, vs2, use_vd, use_vs1, use_vs2, vm);
    wait_accept();
  endtask

  // One ID per pulse so each unit counter sees a single retirement
  task automatic retire_id(vid_t id);
    for (int u = 0; u < NR_UNITS; u++) begin
      vinsn_done_i[u][id] = mrun[u][id];
    end
    next_cycle();
    vinsn_done_i = '0;
  endtask

  task automatic retire_random();
    insn_mask_t run;
    int start, pick;
    run   = running_set();
    start = int'(next_rand() % NR_VINSN);
    pick  = -1;
    for (int k = 0; k < NR_VINSN; k++) begin
      if (pick < 0 && run[(start + k) % NR_VINSN]) pick = (start + k) % NR_VINSN;
    end
    if (pick >= 0) retire_id(vid_t'(pick));
  endtask

  task automatic retire_all();
    insn_mask_t run;
    for (int i = 0; i < NR_VINSN; i++) begin
      run = running_set();
      if (run[i]) retire_id(vid_t'(i));
    end
  endtask

  function automatic logic can_issue(op_e op, logic vm);
    unit_mask_t targets;
    targets = unit_set(op, vm);
    if (&running_set()) return 1'b0;
    for (int u = 0; u < NR_UNITS; u++) begin
      if (targets[u] && $countones(mrun[u]) >= QUEUE_DEPTH) return 1'b0;
    end
    return 1'b1;
  endfunction

  initial begin
    logic [31:0] r;
    op_e         op;
    logic        vm;
    vid_t        p, c;
    req_valid_i    = 1'b0;
    req_op_i       = OP_ADD;
    req_vd_i       = '0;
    req_vs1_i      = '0;
    req_vs2_i      = '0;
    req_use_vd_i   = 1'b0;
    req_use_vs1_i  = 1'b0;
    req_use_vs2_i  = 1'b0;
    req_vm_i       = 1'b1;
    pe_req_ready_i = 1'b1;
    vinsn_done_i   = '0;
    addrgen_ack_i  = 1'b0;
    rng_state      = SEED;
    bp_state       = xorshift32(SEED);
    bp_enable      = 1'b0;
    mwait          = 1'b0;
    last_id        = '0;
    for (int u = 0; u < NR_UNITS; u++) mrun[u] = '0;
    for (int i = 0; i < NR_VINSN; i++) mtable[i] = '0;
    for (int k = 0; k < NR_VREGS; k++) begin
      wr_id[k] = '0;
      rd_id[k] = '0;
      wr_v[k]  = 1'b0;
      rd_v[k]  = 1'b0;
    end

    // Reset state
    wait (rst_n);
    @(negedge clk);
    check_bit("idle_o", idle_o, 1'b1);
    check_bit("pe_req_valid_o", pe_req_valid_o, 1'b0);
    check_bit("resp_valid_o", resp_valid_o, 1'b0);
    check_mask("vinsn_running_o", vinsn_running_o, '0);
    next_cycle();

    // Independent instructions take IDs 0 to 3
    issue_insn(OP_ADD, 5'd1, 5'd0, 5'd0, 1'b1, 1'b0, 1'b0, 1'b1);
    issue_insn(OP_MUL, 5'd2, 5'd0, 5'd0, 1'b1, 1'b0, 1'b0, 1'b1);
    issue_insn(OP_SUB, 5'd3, 5'd0, 5'd0, 1'b1, 1'b0, 1'b0, 1'b1);
    issue_insn(OP_MUL, 5'd4, 5'd0, 5'd0, 1'b1, 1'b0, 1'b0, 1'b1);
    @(negedge clk);
    check_mask("vinsn_running_o", vinsn_running_o, 8'h0f);
    next_cycle();
    retire_id(3'd2);
    retire_id(3'd0);
    retire_id(3'd3);
    retire_id(3'd1);
    @(negedge clk);
    check_bit("idle_o", idle_o, 1'b1);
    next_cycle();

    // A load blocks the dispatcher until its address acknowledge
    issue_insn(OP_LOAD, 5'd8, 5'd0, 5'd0, 1'b1, 1'b0, 1'b0, 1'b1);
    drive_req(OP_ADD, 5'd9, 5'd8, 5'd0, 1'b1, 1'b1, 1'b0, 1'b1);
    repeat (3) begin
      @(negedge clk);
      check_bit("req_ready_o", req_ready_o, 1'b0);
    end
    next_cycle();
    addrgen_ack_i = 1'b1;
    @(negedge clk);
    check_bit("resp_valid_o", resp_valid_o, 1'b1);
    check_bit("req_ready_o", req_ready_o, 1'b0);
    next_cycle();
    addrgen_ack_i = 1'b0;
    @(negedge clk);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    next_cycle();
    req_valid_i = 1'b0;
    retire_all();

    // The multiplier queue fills up and only a done pulse makes room
    issue_insn(OP_MUL, 5'd16, 5'd0, 5'd0, 1'b1, 1'b0, 1'b0, 1'b1);
    p = last_id;
    for (int k = 1; k < QUEUE_DEPTH; k++) begin
      issue_insn(OP_MUL, vreg_t'(16 + k), 5'd0, 5'd0, 1'b1, 1'b0, 1'b0, 1'b1);
    end
    drive_req(OP_MUL, 5'd24, 5'd0, 5'd0, 1'b1, 1'b0, 1'b0, 1'b1);
    repeat (4) begin
      @(negedge clk);
      check_bit("req_ready_o", req_ready_o, 1'b0);
    end
    next_cycle();
    retire_id(p);
    @(negedge clk);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    next_cycle();
    req_valid_i = 1'b0;
    retire_all();

    // A retired producer leaves the table and later hazard vectors
    issue_insn(OP_ADD, 5'd5, 5'd0, 5'd0, 1'b1, 1'b0, 1'b0, 1'b1);
    p = last_id;
    issue_insn(OP_SUB, 5'd6, 5'd5, 5'd0, 1'b1, 1'b1, 1'b0, 1'b1);
    c = last_id;
    @(negedge clk);
    check_mask("global_hazard_table_o[c]", global_hazard_table_o[c], insn_mask_t'(1) << p);
    next_cycle();
    retire_id(p);
    @(negedge clk);
    check_mask("global_hazard_table_o[c]", global_hazard_table_o[c], '0);
    next_cycle();
    issue_insn(OP_ADD, 5'd7, 5'd5, 5'd0, 1'b1, 1'b1, 1'b0, 1'b1);
    retire_all();

    // Random dependent stream over the registers v0 to v7
    bp_enable = 1'b1;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r = next_rand();
      case (r[1:0])
        2'd0:    op = OP_SUB;
        2'd1:    op = OP_MUL;
        default: op = OP_ADD;
      endcase
      vm = r[2] | r[3];
      while (!can_issue(op, vm)) retire_random();
      if (r[4] && running_set() != '0) retire_random();
      issue_insn(op, vreg_t'(r[7:5]), vreg_t'(r[10:8]), vreg_t'(r[13:11]),
                 r[14] | r[15], r[16], r[17], vm);
    end
    bp_enable = 1'b0;
    for (int k = 0; k < ACCEPT_LIMIT && exp_q.size() != 0; k++) next_cycle();
    retire_all();
    @(negedge clk);
    if (exp_q.size() != 0) begin
      abort_run("A request to the units was never consumed");
    end else begin
      check_bit("idle_o", idle_o, 1'b1);
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* project.f */
source/vseq_pkg.sv
source/vseq_issue_if.sv
source/vinsn_tracker.sv
source/vreg_scoreboard.sv
source/unit_queue_counters.sv
source/issue_ctrl.sv
source/vseq_top.sv
verification/tb_clock_gen.sv
verification/tb_vseq.sv

/* Bender.yml */
package:
  name: vseq

sources:
  - files:
      - source/vseq_pkg.sv
      - source/vseq_issue_if.sv
      - source/vinsn_tracker.sv
      - source/vreg_scoreboard.sv
      - source/unit_queue_counters.sv
      - source/issue_ctrl.sv
      - source/vseq_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_vseq.sv
